/* Makefile */
# Verilator flow for the integer to float unit.
TOP := itof_unit_tb

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --assert --top-module $(TOP) -f itof_unit.f

sim:
	verilator --binary --timing --assert --top-module $(TOP) -f itof_unit.f -Mdir obj_dir
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "TEST PASS"

clean:
	rm -rf obj_dir

/* itof_unit.f */
+incdir+source
source/itof_pkg.sv
source/float_rounding.sv
source/int_to_float.sv
source/result_fifo.sv
source/result_drain.sv
source/itof_unit.sv
verification/itof_unit_tb.sv

/* source/float_rounding.sv */
// Combinational rounding of a normalized mantissa.
// Applies the five RISC-V rounding modes and reports inexact.

`include "itof_macros.svh"

module float_rounding (
    input  logic [`ITOF_MANT_W-1:0] mant,
    input  logic signed [9:0]       exp,
    input  logic                    sign,
    input  logic                    guard,
    input  logic                    round_bit,
    input  logic                    sticky,
    input  itof_pkg::round_mode_t   rm,
    output logic [`ITOF_MANT_W-1:0] round_mant,
    output logic [9:0]              round_exp,
    output logic                    inexact
);

    logic                  incr;
    logic [`ITOF_MANT_W:0] sum;

    // Any discarded bit set means the result cannot be exact.
    assign inexact = guard | round_bit | sticky;

    // Increment decision per mode.
    always_comb begin
        case (rm)
            itof_pkg::rtz: begin
                incr = 1'b0;
            end
            itof_pkg::rdn: begin
                // Moving toward minus infinity grows a negative magnitude.
                incr = sign & inexact;
            end
            itof_pkg::rup: begin
                incr = ~sign & inexact;
            end
            itof_pkg::rmm: begin
                // Ties go away from zero, so guard alone decides.
                incr = guard;
            end
            default: begin
                // Nearest-even covers the undefined mode codes as well.
                incr = guard & (round_bit | sticky | mant[0]);
            end
        endcase
    end

    assign sum = {1'b0, mant} + {{`ITOF_MANT_W{1'b0}}, incr};

    // A carry out means the mantissa wrapped to a power of two.
    // Shift it back into place and bump the exponent.
    always_comb begin
        if (sum[`ITOF_MANT_W]) begin
            round_mant = sum[`ITOF_MANT_W:1];
            round_exp  = exp + 10'sd1;
        end else begin
            round_mant = sum[`ITOF_MANT_W-1:0];
            round_exp  = exp;
        end
    end

endmodule

/* source/int_to_float.sv */
// Multi-cycle signed integer to single-precision float converter.
// Takes the magnitude, normalizes one bit per cycle, rounds and packs,
// then pushes the float and its inexact bit into the result queue.

`include "itof_macros.svh"

module int_to_float (
    input  logic                     clk,
    input  logic                     rst,
    input  logic [`ITOF_WIDTH-1:0]   operand,
    input  itof_pkg::round_mode_t    rm,
    input  logic                     operand_stb,
    input  logic                     full,
    output logic                     busy,
    output logic                     push,
    output logic [`ITOF_ENTRY_W-1:0] push_data
);

    itof_pkg::conv_state_t state;
    itof_pkg::round_mode_t rm_reg;

    logic [`ITOF_WIDTH-1:0]  op_reg;
    logic [`ITOF_WIDTH-1:0]  magnitude;
    logic                    sign_reg;
    logic                    zero_reg;
    logic [`ITOF_MANT_W-1:0] mant_reg;
    logic [7:0]              rem_reg;
    logic signed [9:0]       exp_reg;
    logic                    guard_reg;
    logic                    round_reg;
    logic                    sticky_reg;
    logic [`ITOF_WIDTH-1:0]  float_reg;
    logic                    inexact_reg;

    logic [`ITOF_MANT_W-1:0] round_mant;
    logic [9:0]              round_exp;
    logic [9:0]              biased_exp;
    logic                    round_inexact;
    logic                    accept;

    // Negating the most negative value gives 0x80000000, which is
    // the correct magnitude when read as unsigned.
    assign magnitude  = op_reg[`ITOF_WIDTH-1] ? -op_reg : op_reg;
    assign biased_exp = round_exp + 10'(`ITOF_EXP_BIAS);

    assign accept    = (state == itof_pkg::idle) && operand_stb;
    assign busy      = (state != itof_pkg::idle);
    assign push      = (state == itof_pkg::put) && !full;
    assign push_data = {inexact_reg, float_reg};

    float_rounding u_rounding (
        .mant       (mant_reg),
        .exp        (exp_reg),
        .sign       (sign_reg),
        .guard      (guard_reg),
        .round_bit  (round_reg),
        .sticky     (sticky_reg),
        .rm         (rm_reg),
        .round_mant (round_mant),
        .round_exp  (round_exp),
        .inexact    (round_inexact)
    );

    // State sequencing.
    always_ff @(posedge clk) begin
        if (!rst) begin
            state <= itof_pkg::idle;
        end else begin
            case (state)
                itof_pkg::idle: begin
                    if (operand_stb) begin
                        if (operand == '0) begin
                            state <= itof_pkg::pack;
                        end else begin
                            state <= itof_pkg::absolute;
                        end
                    end
                end
                itof_pkg::absolute: begin
                    state <= itof_pkg::normalize;
                end
                itof_pkg::normalize: begin
                    if (mant_reg[`ITOF_MANT_W-1]) begin
                        state <= itof_pkg::pack;
                    end
                end
                itof_pkg::pack: begin
                    state <= itof_pkg::put;
                end
                itof_pkg::put: begin
                    // Hold here under back-pressure.
                    if (!full) begin
                        state <= itof_pkg::idle;
                    end
                end
                default: begin
                    state <= itof_pkg::idle;
                end
            endcase
        end
    end

    // Datapath registers.
    always_ff @(posedge clk) begin
        if (accept) begin
            op_reg   <= operand;
            rm_reg   <= rm;
            zero_reg <= (operand == '0);
        end
        if (state == itof_pkg::absolute) begin
            sign_reg <= op_reg[`ITOF_WIDTH-1];
            mant_reg <= magnitude[`ITOF_WIDTH-1:8];
            rem_reg  <= magnitude[7:0];
            exp_reg  <= 10'sd31;
        end
        if (state == itof_pkg::normalize) begin
            if (!mant_reg[`ITOF_MANT_W-1]) begin
                mant_reg <= {mant_reg[`ITOF_MANT_W-2:0], rem_reg[7]};
                rem_reg  <= {rem_reg[6:0], 1'b0};
                exp_reg  <= exp_reg - 10'sd1;
            end else begin
                guard_reg  <= rem_reg[7];
                round_reg  <= rem_reg[6];
                sticky_reg <= (rem_reg[5:0] != '0);
            end
        end
        if (state == itof_pkg::pack) begin
            if (zero_reg) begin
                float_reg   <= '0;
                inexact_reg <= 1'b0;
            end else begin
                float_reg   <= {sign_reg, biased_exp[7:0], round_mant[`ITOF_MANT_W-2:0]};
                inexact_reg <= round_inexact;
            end
        end
    end

    // The FSM never leaves its five encodings.
    a_state_legal: assert property (@(posedge clk) disable iff (!rst)
        state inside {itof_pkg::idle, itof_pkg::absolute, itof_pkg::normalize,
                      itof_pkg::pack, itof_pkg::put})
        else $error("int_to_float: illegal state %0d", state);

endmodule

/* source/itof_macros.svh */
// Width and depth constants for the integer to float converter.
// Shared by the RTL and the testbench.

`ifndef ITOF_MACROS_SVH
`define ITOF_MACROS_SVH

// Width of the integer operand and of the float result.
`define ITOF_WIDTH 32

// Mantissa width with the hidden bit.
`define ITOF_MANT_W 24

// Single-precision exponent bias.
`define ITOF_EXP_BIAS 127

// Default number of entries in the result queue.
`define ITOF_QUEUE_DEPTH 4

// A queue entry holds the inexact bit on top of the packed float.
`define ITOF_ENTRY_W 33

`endif

/* source/itof_pkg.sv */
// Shared types for the integer to float converter.
// Rounding modes, converter FSM states and result classes.

package itof_pkg;

    // RISC-V rounding mode encodings.
    // Codes 5 to 7 are not defined here and round as nearest-even.
    typedef enum logic [2:0] {
        rne = 3'd0,
        rtz = 3'd1,
        rdn = 3'd2,
        rup = 3'd3,
        rmm = 3'd4
    } round_mode_t;

    // States of the converter FSM.
    // A zero operand skips absolute and normalize.
    typedef enum logic [2:0] {
        idle      = 3'd0,
        absolute  = 3'd1,
        normalize = 3'd2,
        pack      = 3'd3,
        put       = 3'd4
    } conv_state_t;

    // Coarse class of a finished result.
    // Integer inputs never give subnormals, infinities or NaNs.
    typedef enum logic [1:0] {
        class_zero       = 2'd0,
        class_pos_normal = 2'd1,
        class_neg_normal = 2'd2
    } result_class_t;

endpackage

/* source/itof_unit.sv */
// Top level of the integer to float unit.
// Converter feeds the result queue, which the drain empties.

`include "itof_macros.svh"

module itof_unit (
    input  logic                    clk,
    input  logic                    rst,
    input  logic [`ITOF_WIDTH-1:0]  operand,
    input  itof_pkg::round_mode_t   rm,
    input  logic                    operand_stb,
    output logic                    busy,
    input  logic                    drain,
    output logic [`ITOF_WIDTH-1:0]  result,
    output logic                    result_inexact,
    output itof_pkg::result_class_t result_class,
    output logic                    result_stb
);

    logic                     push;
    logic [`ITOF_ENTRY_W-1:0] push_data;
    logic                     pop;
    logic [`ITOF_ENTRY_W-1:0] pop_data;
    logic                     full;
    logic                     empty;

    int_to_float u_convert (
        .clk         (clk),
        .rst         (rst),
        .operand     (operand),
        .rm          (rm),
        .operand_stb (operand_stb),
        .full        (full),
        .busy        (busy),
        .push        (push),
        .push_data   (push_data)
    );

    result_fifo #(
        .depth (`ITOF_QUEUE_DEPTH)
    ) u_queue (
        .clk       (clk),
        .rst       (rst),
        .push      (push),
        .push_data (push_data),
        .pop       (pop),
        .pop_data  (pop_data),
        .full      (full),
        .empty     (empty)
    );

    result_drain u_drain (
        .clk            (clk),
        .rst            (rst),
        .drain          (drain),
        .empty          (empty),
        .pop_data       (pop_data),
        .pop            (pop),
        .result         (result),
        .result_inexact (result_inexact),
        .result_class   (result_class),
        .result_stb     (result_stb)
    );

endmodule

/* source/result_drain.sv */
// Result consumer.
// Pops the queue while drain is high and presents each float
// with a one-cycle strobe, its inexact flag and a coarse class.

`include "itof_macros.svh"

module result_drain (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        drain,
    input  logic                        empty,
    input  logic [`ITOF_ENTRY_W-1:0]    pop_data,
    output logic                        pop,
    output logic [`ITOF_WIDTH-1:0]      result,
    output logic                        result_inexact,
    output itof_pkg::result_class_t     result_class,
    output logic                        result_stb
);

    logic [`ITOF_WIDTH-1:0]  head_float;
    logic                    head_sign;
    logic [7:0]              head_exp;
    itof_pkg::result_class_t head_class;

    assign pop = drain && !empty;

    assign head_float = pop_data[`ITOF_WIDTH-1:0];
    assign head_sign  = head_float[`ITOF_WIDTH-1];
    assign head_exp   = head_float[30:23];

    // Integers convert to zero or to a normal number only.
    always_comb begin
        if (head_exp == '0) begin
            head_class = itof_pkg::class_zero;
        end else if (head_sign) begin
            head_class = itof_pkg::class_neg_normal;
        end else begin
            head_class = itof_pkg::class_pos_normal;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            result_stb <= 1'b0;
        end else begin
            result_stb <= pop;
        end
    end

    // Payload is only meaningful while result_stb is high.
    always_ff @(posedge clk) begin
        if (pop) begin
            result         <= head_float;
            result_inexact <= pop_data[`ITOF_ENTRY_W-1];
            result_class   <= head_class;
        end
    end

endmodule

/* source/result_fifo.sv */
// Synchronous result queue.
// Circular buffer with read and write pointers and an occupancy count.

`include "itof_macros.svh"

module result_fifo #(
    parameter int depth = `ITOF_QUEUE_DEPTH
) (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     push,
    input  logic [`ITOF_ENTRY_W-1:0] push_data,
    input  logic                     pop,
    output logic [`ITOF_ENTRY_W-1:0] pop_data,
    output logic                     full,
    output logic                     empty
);

    localparam int ptr_w = (depth > 1) ? $clog2(depth) : 1;
    localparam int cnt_w = $clog2(depth + 1);

    logic [`ITOF_ENTRY_W-1:0] mem [depth];
    logic [ptr_w-1:0]         wr_ptr;
    logic [ptr_w-1:0]         rd_ptr;
    logic [cnt_w-1:0]         count;
    logic                     do_push;
    logic                     do_pop;

    assign full     = (count == cnt_w'(depth));
    assign empty    = (count == '0);
    assign do_push  = push && !full;
    assign do_pop   = pop && !empty;
    assign pop_data = mem[rd_ptr];

    // Entries are written at the write pointer and read at the head.
    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= push_data;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= (wr_ptr == ptr_w'(depth - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == ptr_w'(depth - 1)) ? '0 : rd_ptr + 1'b1;
            end
            // Push and pop in the same cycle leave the count alone.
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // The converter must stall rather than overrun the queue.
    a_no_overflow: assert property (@(posedge clk) disable iff (!rst)
        push |-> !full)
        else $error("result_fifo: push while full");

    // The drain must only pop a non-empty queue.
    a_no_underflow: assert property (@(posedge clk) disable iff (!rst)
        pop |-> !empty)
        else $error("result_fifo: pop while empty");

endmodule

/* verification/itof_unit_tb.sv */
// Testbench for the integer to float unit.
// Table-driven directed cases, a back-pressure case and random operands
// checked against a reference conversion model through a scoreboard.

`include "itof_macros.svh"

module itof_unit_tb;

    typedef struct packed {
        logic [31:0]           operand;
        itof_pkg::round_mode_t mode;
        logic [31:0]           bits;
        logic                  inexact;
    } vector_t;

    localparam int num_operands = 30 + 20 + 5 + 200;
    localparam int cycle_limit  = num_operands * 40 + 200;

    logic                    clk;
    logic                    rst;
    logic [`ITOF_WIDTH-1:0]  operand;
    itof_pkg::round_mode_t   rm;
    logic                    operand_stb;
    logic                    busy;
    logic                    drain;
    logic [`ITOF_WIDTH-1:0]  result;
    logic                    result_inexact;
    itof_pkg::result_class_t result_class;
    logic                    result_stb;

    // Scoreboard entries are {class, inexact, float bits}.
    logic [34:0] expected_q [$];
    int unsigned lcg_state = 32'd13524;
    int          checks = 0;
    int          errors = 0;
    int          received_count = 0;
    int          cycle_count = 0;
    int          test_checks;
    int          test_errors;

    // Exact operands are expected under every rounding mode with inexact low.
    logic [31:0] exact_operand [6] = '{32'h00000000, 32'h00000001, 32'hFFFFFFFF,
                                       32'd100, 32'h01000000, 32'h80000000};
    logic [31:0] exact_bits [6]    = '{32'h00000000, 32'h3F800000, 32'hBF800000,
                                       32'h42C80000, 32'h4B800000, 32'hCF000000};

    // Inexact operands where the modes disagree are followed by the largest positive integer.
    vector_t round_table [20] = '{
        '{32'h01000001, itof_pkg::rne, 32'h4B800000, 1'b1},
        '{32'h01000001, itof_pkg::rtz, 32'h4B800000, 1'b1},
        '{32'h01000001, itof_pkg::rdn, 32'h4B800000, 1'b1},
        '{32'h01000001, itof_pkg::rup, 32'h4B800001, 1'b1},
        '{32'h01000001, itof_pkg::rmm, 32'h4B800001, 1'b1},
        '{32'h01000003, itof_pkg::rne, 32'h4B800002, 1'b1},
        '{32'h01000003, itof_pkg::rtz, 32'h4B800001, 1'b1},
        '{32'h01000003, itof_pkg::rdn, 32'h4B800001, 1'b1},
        '{32'h01000003, itof_pkg::rup, 32'h4B800002, 1'b1},
        '{32'h01000003, itof_pkg::rmm, 32'h4B800002, 1'b1},
        '{32'hFEFFFFFF, itof_pkg::rne, 32'hCB800000, 1'b1},
        '{32'hFEFFFFFF, itof_pkg::rtz, 32'hCB800000, 1'b1},
        '{32'hFEFFFFFF, itof_pkg::rdn, 32'hCB800001, 1'b1},
        '{32'hFEFFFFFF, itof_pkg::rup, 32'hCB800000, 1'b1},
        '{32'hFEFFFFFF, itof_pkg::rmm, 32'hCB800001, 1'b1},
        '{32'h7FFFFFFF, itof_pkg::rne, 32'h4F000000, 1'b1},
        '{32'h7FFFFFFF, itof_pkg::rtz, 32'h4EFFFFFF, 1'b1},
        '{32'h7FFFFFFF, itof_pkg::rdn, 32'h4EFFFFFF, 1'b1},
        '{32'h7FFFFFFF, itof_pkg::rup, 32'h4F000000, 1'b1},
        '{32'h7FFFFFFF, itof_pkg::rmm, 32'h4F000000, 1'b1}
    };

    itof_unit dut (
        .clk            (clk),
        .rst            (rst),
        .operand        (operand),
        .rm             (rm),
        .operand_stb    (operand_stb),
        .busy           (busy),
        .drain          (drain),
        .result         (result),
        .result_inexact (result_inexact),
        .result_class   (result_class),
        .result_stb     (result_stb)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic logic [15:0] lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state[31:16];
    endfunction

    function automatic logic [1:0] class_of(input logic [31:0] op);
        if (op == 32'd0) begin
            return itof_pkg::class_zero;
        end else if (op[31]) begin
            return itof_pkg::class_neg_normal;
        end
        return itof_pkg::class_pos_normal;
    endfunction

    // Reference conversion. Returns {inexact, float bits}.
    // The discarded part is compared against half an ulp of the kept part.
    function automatic logic [32:0] ref_convert(input logic [31:0] op,
                                                input itof_pkg::round_mode_t mode);
        logic        sign;
        logic [31:0] mag;
        logic [31:0] kept;
        logic [31:0] rem;
        logic [31:0] half;
        logic        up;
        logic [7:0]  e;
        int          msb;
        int          shift;
        sign = op[31];
        mag  = sign ? (~op + 32'd1) : op;
        if (mag == 32'd0) begin
            return 33'd0;
        end
        msb = 31;
        while (!mag[msb]) begin
            msb = msb - 1;
        end
        shift = (msb > 23) ? msb - 23 : 0;
        if (shift == 0) begin
            kept = mag << (23 - msb);
            rem  = 32'd0;
            half = 32'd0;
        end else begin
            kept = mag >> shift;
            rem  = mag & ((32'd1 << shift) - 32'd1);
            half = 32'd1 << (shift - 1);
        end
        case (mode)
            itof_pkg::rtz: up = 1'b0;
            itof_pkg::rdn: up = sign && (rem != 32'd0);
            itof_pkg::rup: up = !sign && (rem != 32'd0);
            itof_pkg::rmm: up = (shift > 0) && (rem >= half);
            default:       up = (shift > 0) && ((rem > half) || (rem == half && kept[0]));
        endcase
        kept = kept + {31'd0, up};
        e    = 8'(msb + `ITOF_EXP_BIAS);
        if (kept[24]) begin
            kept = kept >> 1;
            e    = e + 8'd1;
        end
        return {rem != 32'd0, sign, e, kept[22:0]};
    endfunction

    // Waits for the converter to go idle, then strobes one operand.
    task automatic send_operand(input logic [31:0] op, input itof_pkg::round_mode_t mode,
                                input logic [31:0] exp_bits, input logic exp_inexact,
                                input bit toggle_drain);
        logic [15:0] rnd;
        @(posedge clk);
        #1;
        while (busy) begin
            if (toggle_drain) begin
                rnd   = lcg_next();
                drain = rnd[15];
            end
            @(posedge clk);
            #1;
        end
        operand     = op;
        rm          = mode;
        operand_stb = 1'b1;
        expected_q.push_back({class_of(op), exp_inexact, exp_bits});
        @(posedge clk);
        #1;
        operand_stb = 1'b0;
    endtask

    task automatic start_test();
        test_checks = checks;
        test_errors = errors;
    endtask

    // Drains the queue until every expected result has arrived.
    task automatic end_test(input string name);
        drain = 1'b1;
        while (expected_q.size() != 0 || busy) begin
            @(posedge clk);
            #1;
        end
        repeat (2) @(posedge clk);
        $display("Test %s: %0d checks, %0d errors", name,
                 checks - test_checks, errors - test_errors);
    endtask

    // Scoreboard. Outputs are sampled on the falling edge.
    always @(negedge clk) begin : scoreboard
        logic [34:0] entry;
        if (rst && result_stb) begin
            received_count++;
            assert (expected_q.size() != 0)
            else begin
                $display("Error at time %0t: a result arrived with no operand waiting", $time);
                errors++;
            end
            if (expected_q.size() != 0) begin
                entry = expected_q.pop_front();
                checks++;
                assert (result == entry[31:0] && result_inexact == entry[32]
                        && result_class == entry[34:33])
                else begin
                    $display("Fail at time %0t: got %h inexact %b class %0d, expected %h %b %0d",
                             $time, result, result_inexact, result_class,
                             entry[31:0], entry[32], entry[34:33]);
                    errors++;
                end
            end
        end
    end

    initial begin : watchdog
        while (cycle_count < cycle_limit) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("Timeout: results stopped arriving within %0d cycles", cycle_limit);
        $display("TEST FAIL");
        $finish;
    end

    initial begin
        logic [32:0]           model;
        logic [15:0]           hi;
        logic [15:0]           lo;
        logic [15:0]           rnd;
        logic [31:0]           op;
        logic [2:0]            mode_code;
        itof_pkg::round_mode_t mode;
        int                    snap_received;
        rst         = 1'b0;
        operand     = '0;
        rm          = itof_pkg::rne;
        operand_stb = 1'b0;
        drain       = 1'b0;
        repeat (3) @(posedge clk);
        #1;
        rst = 1'b1;

        start_test();
        drain = 1'b1;
        for (int i = 0; i < 6; i++) begin
            for (int m = 0; m < 5; m++) begin
                send_operand(exact_operand[i], itof_pkg::round_mode_t'(m),
                             exact_bits[i], 1'b0, 1'b0);
            end
        end
        end_test("exact values and classes");

        start_test();
        for (int i = 0; i < 20; i++) begin
            // The table and the model must agree before the DUT is judged.
            model = ref_convert(round_table[i].operand, round_table[i].mode);
            checks++;
            assert (model == {round_table[i].inexact, round_table[i].bits})
            else begin
                $display("Fail at time %0t: model gives %h for table row %0d", $time, model, i);
                errors++;
            end
            send_operand(round_table[i].operand, round_table[i].mode,
                         round_table[i].bits, round_table[i].inexact, 1'b0);
        end
        end_test("rounding modes and extremes");

        start_test();
        drain = 1'b0;
        snap_received = received_count;
        foreach (exact_bits[i]) begin
            if (i < 5) begin
                op    = (i == 0) ? 32'd7 : 32'd123456789 * i - 32'd300;
                model = ref_convert(op, itof_pkg::rne);
                send_operand(op, itof_pkg::rne, model[31:0], model[32], 1'b0);
            end
        end
        // Longest conversion is well under 40 cycles, so the fifth must be stalled.
        repeat (40) @(posedge clk);
        #1;
        checks++;
        assert (busy && received_count == snap_received && expected_q.size() == 5)
        else begin
            $display("Fail at time %0t: busy %b, %0d results out, %0d pending with drain low",
                     $time, busy, received_count - snap_received, expected_q.size());
            errors++;
        end
        end_test("back-pressure with drain low");

        start_test();
        for (int n = 0; n < 200; n++) begin
            hi        = lcg_next();
            lo        = lcg_next();
            rnd       = lcg_next();
            op        = $signed({hi, lo}) >>> rnd[4:0];
            mode_code = 3'(rnd[15:8] % 8'd5);
            mode      = itof_pkg::round_mode_t'(mode_code);
            model     = ref_convert(op, mode);
            send_operand(op, mode, model[31:0], model[32], 1'b1);
        end
        end_test("random operands with random drain");

        $display("Summary: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule
